/* common/host_pkg.sv */
// ascii frame format: L, 7 count digits, 8 command, 8 address, count+1 data words; upper case hex

package host_pkg;

    // frame start character
    localparam logic [7:0] char_start = 8'h4c;

    // valid digit ranges, 0-9 and A-F only
    localparam logic [7:0] char_0 = 8'h30;
    localparam logic [7:0] char_9 = 8'h39;
    localparam logic [7:0] char_a = 8'h41;
    localparam logic [7:0] char_f = 8'h46;

    // hex digits per field
    localparam int count_digits = 7;
    localparam int word_digits = 8;

    // field widths
    localparam int word_w = 32;
    localparam int count_w = 28;

    // digit counter covers the longest field
    localparam int digit_cnt_w = $clog2(word_digits);

    // parser fsm encoding
    localparam int state_w = 3;
    localparam logic [state_w-1:0] wait_start = 3'd0;
    localparam logic [state_w-1:0] read_count = 3'd1;
    localparam logic [state_w-1:0] read_command = 3'd2;
    localparam logic [state_w-1:0] read_address = 3'd3;
    localparam logic [state_w-1:0] read_data = 3'd4;

endpackage

/* common/uart_pkg.sv */
// fixed 8N1 line timing only; no parity, no runtime baud select, clks_per_bit must be even

package uart_pkg;

    // clock cycles per serial bit
    localparam int clks_per_bit = 16;

    // sample point inside a bit, counted from its leading edge
    localparam int half_bit = clks_per_bit / 2;

    // data bits per character, lsb first on the line
    localparam int data_bits = 8;

    // counter widths for the bit timer and the bit index
    localparam int timer_w = $clog2(clks_per_bit);
    localparam int bit_idx_w = $clog2(data_bits);

    // receiver fsm encoding
    localparam int rx_state_w = 2;
    localparam logic [rx_state_w-1:0] rx_idle = 2'd0;
    localparam logic [rx_state_w-1:0] rx_start = 2'd1;
    localparam logic [rx_state_w-1:0] rx_data = 2'd2;
    localparam logic [rx_state_w-1:0] rx_stop = 2'd3;

endpackage

/* compile.f */
+incdir+tb
common/uart_pkg.sv
common/host_pkg.sv
uart/uart_rx.sv
design/uart_input_handler.sv
design/host_rx_top.sv
tb/tb_top.sv

/* design/host_rx_top.sv */
// rx is async and idle high; no transmit path, no flow control, ready is a one-cycle pulse
`timescale 1ns/1ns

module host_rx_top (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        rx,
    output logic [host_pkg::word_w-1:0] command,
    output logic [host_pkg::word_w-1:0] address,
    output logic [host_pkg::word_w-1:0] data,
    output logic                        ready
);

    // byte path from receiver to parser
    logic [uart_pkg::data_bits-1:0] rx_byte;
    logic                           byte_available;

    // serial to bytes
    uart_rx u_uart_rx (
        .clk            (clk),
        .rst            (rst),
        .rx             (rx),
        .rx_byte        (rx_byte),
        .byte_available (byte_available)
    );

    // bytes to command, address and data words
    uart_input_handler u_uart_input_handler (
        .clk            (clk),
        .rst            (rst),
        .byte_available (byte_available),
        .rx_byte        (rx_byte),
        .command        (command),
        .address        (address),
        .data           (data),
        .ready          (ready)
    );

endmodule

/* design/uart_input_handler.sv */
// takes every byte_available strobe, no back-pressure; words hold until the next L clears them
`timescale 1ns/1ns

module uart_input_handler (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           byte_available,
    input  logic [uart_pkg::data_bits-1:0] rx_byte,
    output logic [host_pkg::word_w-1:0]    command,
    output logic [host_pkg::word_w-1:0]    address,
    output logic [host_pkg::word_w-1:0]    data,
    output logic                           ready
);

    logic [host_pkg::state_w-1:0]     state;
    logic [host_pkg::digit_cnt_w-1:0] digit_cnt;

    // data words still to come after the current one
    logic [host_pkg::count_w-1:0] words_left;

    // data word being assembled, copied to data when complete
    logic [host_pkg::word_w-1:0] data_acc;

    // hex converter
    logic                           is_num;
    logic                           is_alpha;
    logic                           hex_valid;
    logic [uart_pkg::data_bits-1:0] digit_value;
    logic [3:0]                     nibble;

    // last digit of the field in progress
    logic last_digit;

    always_comb begin
        is_num   = (rx_byte >= host_pkg::char_0) && (rx_byte <= host_pkg::char_9);
        is_alpha = (rx_byte >= host_pkg::char_a) && (rx_byte <= host_pkg::char_f);
        // exactly 0-9 and A-F, nothing in between
        hex_valid = is_num || is_alpha;
        if (is_alpha) begin
            digit_value = rx_byte - host_pkg::char_a + 8'd10;
        end else begin
            digit_value = rx_byte - host_pkg::char_0;
        end
        nibble = digit_value[3:0];
    end

    // count field is one digit shorter than the word fields
    always_comb begin
        if (state == host_pkg::read_count) begin
            last_digit = (digit_cnt == host_pkg::digit_cnt_w'(host_pkg::count_digits - 1));
        end else begin
            last_digit = (digit_cnt == host_pkg::digit_cnt_w'(host_pkg::word_digits - 1));
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= host_pkg::wait_start;
            digit_cnt  <= '0;
            words_left <= '0;
            command    <= '0;
            address    <= '0;
            data       <= '0;
            ready      <= 1'b0;
        end else begin
            // pulse only
            ready <= 1'b0;
            if (byte_available) begin
                case (state)
                    host_pkg::wait_start: begin
                        // anything but L is ignored here
                        if (rx_byte == host_pkg::char_start) begin
                            state      <= host_pkg::read_count;
                            digit_cnt  <= '0;
                            words_left <= '0;
                            // previous frame's words dropped on a new L
                            command    <= '0;
                            address    <= '0;
                            data       <= '0;
                        end
                    end
                    host_pkg::read_count,
                    host_pkg::read_command,
                    host_pkg::read_address,
                    host_pkg::read_data: begin
                        if (!hex_valid) begin
                            // abandon frame, wait for a new L
                            state <= host_pkg::wait_start;
                        end else begin
                            if (last_digit) begin
                                digit_cnt <= '0;
                            end else begin
                                digit_cnt <= digit_cnt + 1'b1;
                            end
                            // msb first into the field of this state
                            case (state)
                                host_pkg::read_count: begin
                                    words_left <= {words_left[host_pkg::count_w-5:0], nibble};
                                    if (last_digit) begin
                                        state <= host_pkg::read_command;
                                    end
                                end
                                host_pkg::read_command: begin
                                    command <= {command[host_pkg::word_w-5:0], nibble};
                                    if (last_digit) begin
                                        state <= host_pkg::read_address;
                                    end
                                end
                                host_pkg::read_address: begin
                                    address <= {address[host_pkg::word_w-5:0], nibble};
                                    if (last_digit) begin
                                        state <= host_pkg::read_data;
                                    end
                                end
                                default: begin
                                    data_acc <= {data_acc[host_pkg::word_w-5:0], nibble};
                                    if (last_digit) begin
                                        // word complete, publish and flag
                                        data  <= {data_acc[host_pkg::word_w-5:0], nibble};
                                        ready <= 1'b1;
                                        if (words_left == '0) begin
                                            state <= host_pkg::wait_start;
                                        end else begin
                                            words_left <= words_left - 1'b1;
                                        end
                                    end
                                end
                            endcase
                        end
                    end
                    default: begin
                        state <= host_pkg::wait_start;
                    end
                endcase
            end
        end
    end

endmodule

/* tb/tb_uart_tasks.svh */
// rx driven on falling clk edges at uart_pkg::clks_per_bit; callers must start on a falling edge
`ifndef tb_uart_tasks_svh
`define tb_uart_tasks_svh

    // data words of the next frame, filled by the caller before send_frame
    logic [host_pkg::word_w-1:0] frame_words [8];

    // one 8N1 character, lsb first; stop_level low gives a framing error
    task automatic send_byte(input logic [7:0] value, input logic stop_level);
        int i;
        // start bit
        rx = 1'b0;
        repeat (uart_pkg::clks_per_bit) @(negedge clk);
        for (i = 0; i < 8; i++) begin
            rx = value[i];
            repeat (uart_pkg::clks_per_bit) @(negedge clk);
        end
        rx = stop_level;
        repeat (uart_pkg::clks_per_bit) @(negedge clk);
        rx = 1'b1;
        // receiver waits for the line to go high after a bad stop bit
        if (!stop_level) begin
            repeat (uart_pkg::clks_per_bit) @(negedge clk);
        end
    endtask

    // plain ascii string, every character with a good stop bit
    task automatic send_text(input string text);
        int i;
        for (i = 0; i < text.len(); i++) begin
            send_byte(text[i], 1'b1);
        end
    endtask

    // value as upper case hex, msb digit first
    task automatic send_hex(input logic [31:0] value, input int digits);
        int i;
        logic [3:0] nib;
        logic [7:0] ch;
        for (i = digits - 1; i >= 0; i--) begin
            nib = value[i*4 +: 4];
            if (nib < 4'd10) begin
                ch = host_pkg::char_0 + 8'(nib);
            end else begin
                // 10..15 map to A..F
                ch = host_pkg::char_a + 8'(nib) - 8'd10;
            end
            send_byte(ch, 1'b1);
        end
    endtask

    // L, count, command, address, then count+1 words from frame_words
    task automatic send_frame(
        input logic [host_pkg::count_w-1:0] count,
        input logic [host_pkg::word_w-1:0]  cmd,
        input logic [host_pkg::word_w-1:0]  addr
    );
        int w;
        send_byte(host_pkg::char_start, 1'b1);
        // count field is 28 bits, padded to the send_hex width
        send_hex({4'b0, count}, host_pkg::count_digits);
        send_hex(cmd, host_pkg::word_digits);
        send_hex(addr, host_pkg::word_digits);
        for (w = 0; w <= int'(count); w++) begin
            send_hex(frame_words[w], host_pkg::word_digits);
        end
    endtask

`endif

/* tb/tb_top.sv */
// drives rx at uart_pkg::clks_per_bit; frames sent here carry at most 8 data words
`timescale 1ns/1ns

module tb_top;

    logic                        clk;
    logic                        rst;
    logic                        rx;
    logic [host_pkg::word_w-1:0] command;
    logic [host_pkg::word_w-1:0] address;
    logic [host_pkg::word_w-1:0] data;
    logic                        ready;

    // expected words with one entry per ready pulse in arrival order
    logic [host_pkg::word_w-1:0] exp_command [$];
    logic [host_pkg::word_w-1:0] exp_address [$];
    logic [host_pkg::word_w-1:0] exp_data [$];

    int pulse_count = 0;
    int value_errors = 0;
    int protocol_errors = 0;
    int timeout_errors = 0;

    host_rx_top DUT (
        .clk     (clk),
        .rst     (rst),
        .rx      (rx),
        .command (command),
        .address (address),
        .data    (data),
        .ready   (ready)
    );

    `include "tb_uart_tasks.svh"

    // 100 ns period
    always #50 clk = ~clk;

    task automatic check_word(
        input string       name,
        input logic [31:0] expected,
        input logic [31:0] actual
    );
        assert (actual === expected) else begin
            $display("Error: %s expected %h actual %h", name, expected, actual);
            value_errors++;
        end
    endtask

    // compare the three words on every ready pulse
    always @(posedge clk) begin
        if (!rst && ready) begin
            pulse_count++;
            if (exp_data.size() == 0) begin
                $display("Unexpected ready pulse with no data word pending at %0t ns", $time);
                protocol_errors++;
            end else begin
                check_word("command", exp_command.pop_front(), command);
                check_word("address", exp_address.pop_front(), address);
                check_word("data", exp_data.pop_front(), data);
            end
        end
    end

    // ready is a single-cycle pulse
    assert property (@(posedge clk) disable iff (rst) ready |=> !ready)
        else begin
            $display("Error: ready expected %h actual %h on the cycle after a pulse",
                     1'b0, $sampled(ready));
            protocol_errors++;
        end

    // wait until pulse_count reaches target or the cycle limit runs out
    task automatic wait_for_pulses(input int target, input string name);
        int cycles;
        cycles = 0;
        while (pulse_count < target && cycles < 20 * uart_pkg::clks_per_bit) begin
            @(negedge clk);
            cycles++;
        end
        if (pulse_count < target) begin
            $display("Timeout: no ready pulse for %s, %0d of its data words missing",
                     name, target - pulse_count);
            timeout_errors++;
        end
    endtask

    // watch a while and make sure nothing new came out
    task automatic expect_silence(input int start_count, input string name);
        int cycles;
        cycles = 0;
        while (cycles < 20 * uart_pkg::clks_per_bit) begin
            @(negedge clk);
            cycles++;
        end
        if (pulse_count != start_count) begin
            $display("Ready pulsed for %s, which must be ignored", name);
        end
        check_word("ready pulses", 32'(start_count), 32'(pulse_count));
    endtask

    // random command, address and data words queued as expectations before sending
    task automatic send_valid_frame(input logic [host_pkg::count_w-1:0] count, input string name);
        logic [host_pkg::word_w-1:0] cmd;
        logic [host_pkg::word_w-1:0] addr;
        int target;
        int w;
        cmd = $urandom;
        addr = $urandom;
        for (w = 0; w <= int'(count); w++) begin
            frame_words[w] = $urandom;
            exp_command.push_back(cmd);
            exp_address.push_back(addr);
            exp_data.push_back(frame_words[w]);
        end
        target = pulse_count + int'(count) + 1;
        send_frame(count, cmd, addr);
        wait_for_pulses(target, name);
    endtask

    initial begin
        int i;
        int start_count;
        void'($urandom(32'he6e1_f3e1));
        clk = 1'b0;
        rst = 1'b1;
        rx = 1'b1;

        // outputs quiet and cleared during reset
        for (i = 0; i < 16; i++) begin
            @(negedge clk);
            check_word("ready", 32'h0, 32'(ready));
            check_word("command", 32'h0, command);
            check_word("address", 32'h0, address);
            check_word("data", 32'h0, data);
        end
        rst = 1'b0;
        // and just after it
        for (i = 0; i < 4; i++) begin
            @(negedge clk);
            check_word("ready", 32'h0, 32'(ready));
            check_word("command", 32'h0, command);
            check_word("address", 32'h0, address);
            check_word("data", 32'h0, data);
        end

        // single data word
        send_valid_frame(28'd0, "count 0 frame");

        // four data words under one command and address
        send_valid_frame(28'd3, "count 3 frame");

        // lower case digit inside the command field
        start_count = pulse_count;
        send_text("L0000000");
        send_hex($urandom, 4);
        send_byte(8'h63, 1'b1);
        send_text("0123456789ABCDEF0123");
        expect_silence(start_count, "frame with a lower case digit");

        // colon inside the address field
        start_count = pulse_count;
        send_text("L0000000");
        send_hex($urandom, 8);
        send_hex($urandom, 3);
        send_text(":");
        send_text("0123456789ABCDEF");
        expect_silence(start_count, "frame with a colon");

        send_valid_frame(28'd1, "frame after broken frames");

        // stray bytes between frames without any L
        start_count = pulse_count;
        send_text("0123456789ABCDEF XYZ face");
        expect_silence(start_count, "stray bytes");
        send_valid_frame(28'd2, "frame after stray bytes");

        // L lost to a bad stop bit and the body sent as if nothing happened
        start_count = pulse_count;
        send_byte(host_pkg::char_start, 1'b0);
        send_hex(32'h0, host_pkg::count_digits);
        send_hex($urandom, host_pkg::word_digits);
        send_hex($urandom, host_pkg::word_digits);
        send_hex($urandom, host_pkg::word_digits);
        expect_silence(start_count, "frame whose L had a bad stop bit");
        send_valid_frame(28'd0, "frame after bad stop bit");

        // every queued word must have been seen
        check_word("pending words", 32'h0, 32'(exp_data.size()));

        $display("value errors %0d, protocol errors %0d, timeouts %0d",
                 value_errors, protocol_errors, timeout_errors);
        if (value_errors == 0 && protocol_errors == 0 && timeout_errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* uart/uart_rx.sv */
// 8N1 only at uart_pkg::clks_per_bit; bytes with a low stop bit are dropped, no error output
`timescale 1ns/1ns

module uart_rx (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           rx,
    output logic [uart_pkg::data_bits-1:0] rx_byte,
    output logic                           byte_available
);

    // two-flop synchroniser on the async pin
    logic rx_meta;
    logic rx_sync;

    logic [uart_pkg::rx_state_w-1:0] state;
    logic [uart_pkg::timer_w-1:0]    timer;
    logic [uart_pkg::bit_idx_w-1:0]  bit_idx;
    logic [uart_pkg::data_bits-1:0]  shift_reg;

    // set when the stop bit sampled low
    logic frame_err;

    // timer end points
    logic half_done;
    logic bit_done;

    assign half_done = (timer == uart_pkg::timer_w'(uart_pkg::half_bit - 1));
    assign bit_done  = (timer == uart_pkg::timer_w'(uart_pkg::clks_per_bit - 1));

    // idle line is high
    always_ff @(posedge clk) begin
        if (rst) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
        end else begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state          <= uart_pkg::rx_idle;
            timer          <= '0;
            bit_idx        <= '0;
            frame_err      <= 1'b0;
            byte_available <= 1'b0;
        end else begin
            // strobe lasts one cycle
            byte_available <= 1'b0;
            case (state)
                uart_pkg::rx_idle: begin
                    timer     <= '0;
                    bit_idx   <= '0;
                    frame_err <= 1'b0;
                    // falling edge starts a possible start bit
                    if (!rx_sync) begin
                        state <= uart_pkg::rx_start;
                    end
                end
                uart_pkg::rx_start: begin
                    if (half_done) begin
                        timer <= '0;
                        // still low at mid bit, a real start bit
                        if (!rx_sync) begin
                            state <= uart_pkg::rx_data;
                        end else begin
                            // glitch, back to idle
                            state <= uart_pkg::rx_idle;
                        end
                    end else begin
                        timer <= timer + 1'b1;
                    end
                end
                uart_pkg::rx_data: begin
                    if (bit_done) begin
                        timer <= '0;
                        // lsb first, shift in from the top
                        shift_reg <= {rx_sync, shift_reg[uart_pkg::data_bits-1:1]};
                        if (bit_idx == uart_pkg::bit_idx_w'(uart_pkg::data_bits - 1)) begin
                            state <= uart_pkg::rx_stop;
                        end else begin
                            bit_idx <= bit_idx + 1'b1;
                        end
                    end else begin
                        timer <= timer + 1'b1;
                    end
                end
                uart_pkg::rx_stop: begin
                    if (frame_err) begin
                        // bad stop bit, wait for the line to return high
                        if (rx_sync) begin
                            state <= uart_pkg::rx_idle;
                        end
                    end else if (bit_done) begin
                        if (rx_sync) begin
                            rx_byte        <= shift_reg;
                            byte_available <= 1'b1;
                            state          <= uart_pkg::rx_idle;
                        end else begin
                            // discard the byte
                            frame_err <= 1'b1;
                        end
                    end else begin
                        timer <= timer + 1'b1;
                    end
                end
                default: begin
                    state <= uart_pkg::rx_idle;
                end
            endcase
        end
    end

endmodule
